// File: test/golden_vectors.hex
// record: tag op_en word_count, the words, then desc_count
// each descriptor: op_type op_num data_addr weight_addr writeback_addr
// test 1, reset only
1 0 0
0
// test 2, loopback of two blocks plus one more
2 0 C
A5A50001 A5A50002 A5A50003 A5A50004
5A5A0010 5A5A0020 5A5A0030 5A5A0040
DEADBEEF 00000000 FFFFFFFF 12345678
0
// test 3, loopback with random gaps
3 0 C
0F0F0F0F F0F0F0F0 13579BDF 2468ACE0
80000001 7FFFFFFE 00C0FFEE CAFE0000
11111111 22222222 33333333 44444444
0
// test 4, three command blocks with op_ready high
4 1 C
1FFF0040 00001000 00002000 C0003000
20000080 3FFFFFFC 01234568 00ABCDE0
4000FFFF 00010000 00020000 00030000
3
0 0040 00001000 00002000 00003000
1 0080 3FFFFFFC 01234568 00ABCDE0
2 FFFF 00010000 00020000 00030000
// test 5, nine command blocks against a held op_ready
5 1 24
00000101 00500100 00600100 00700100
20000102 00500200 00600200 00700200
40000103 80500300 00600300 00700300
60000104 00500400 00600400 00700400
00000105 00500500 00600500 00700500
20000106 00500600 00600600 40700600
40000107 00500700 00600700 00700700
60000108 00500800 00600800 00700800
00000109 00500900 00600900 00700900
9
0 0101 00500100 00600100 00700100
1 0102 00500200 00600200 00700200
2 0103 00500300 00600300 00700300
3 0104 00500400 00600400 00700400
0 0105 00500500 00600500 00700500
1 0106 00500600 00600600 00700600
2 0107 00500700 00600700 00700700
3 0108 00500800 00600800 00700800
0 0109 00500900 00600900 00700900

// File: all.f
logic/fp_pkg.sv
logic/word_fifo.sv
logic/pipe_in_gate.sv
logic/word_router.sv
logic/cmd_decoder.sv
logic/host_bridge_top.sv
test/host_bridge_checker.sv
test/host_bridge_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --timing -Wno-fatal
TOP       ?= host_bridge_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_STR  := TEST OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "^$(PASS_STR)$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation did not pass, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: test/host_bridge_tb.sv
`timescale 1ns/1ps

module host_bridge_tb;

	localparam int BLOCK_WORDS = 4;
	localparam int FIFO_DEPTH  = 32;
	localparam int HEADROOM    = 2;
	localparam int THRESHOLD   = FIFO_DEPTH - HEADROOM - BLOCK_WORDS;
	localparam int TIMEOUT     = 200;    // cycles allowed per wait
	localparam int SEL_PI      = 0;
	localparam int SEL_PO      = 1;
	localparam int SEL_DRAINED = 2;

	logic             okClk;
	logic             rst_n;
	logic             op_en;
	logic             pi_write;
	fp_pkg::word_t    pi_data;
	logic             pi_ready;
	logic             po_read;
	fp_pkg::word_t    po_data;
	logic             po_ready;
	logic             op_valid;
	logic             op_ready;
	fp_pkg::op_desc_t op_desc;

	fp_pkg::word_t golden [256];
	fp_pkg::word_t words [$];    // stimulus of the current record
	int            rp;           // read position in golden
	logic [31:0]   lcg_state;
	bit            halted;
	int            tb_errors;
	int            tests_failed;
	int            tag;
	string         test_names [5] = '{"reset", "loopback order", "gapped loopback",
		"command decode", "back-pressure"};

	host_bridge_top #(
		.BLOCK_WORDS (BLOCK_WORDS),
		.FIFO_DEPTH  (FIFO_DEPTH),
		.HEADROOM    (HEADROOM)
	) dut_i (
		.okClk    (okClk),
		.rst_n    (rst_n),
		.op_en    (op_en),
		.pi_write (pi_write),
		.pi_data  (pi_data),
		.pi_ready (pi_ready),
		.po_read  (po_read),
		.po_data  (po_data),
		.po_ready (po_ready),
		.op_valid (op_valid),
		.op_ready (op_ready),
		.op_desc  (op_desc)
	);

	host_bridge_checker checker_i (
		.okClk    (okClk),
		.rst_n    (rst_n),
		.po_read  (po_read),
		.po_data  (po_data),
		.op_valid (op_valid),
		.op_ready (op_ready),
		.op_desc  (op_desc)
	);

	initial begin
		okClk = 1'b0;
		forever #5 okClk = ~okClk;
	end

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic bit cond_met(input int sel);
		case (sel)
			SEL_PI:  return pi_ready;
			SEL_PO:  return po_ready;
			default: return checker_i.pending() == 0;
		endcase
	endfunction

	// polled on the falling edge away from the drive edge
	task automatic wait_until(input int sel, input string what);
		int n;
		n = 0;
		do begin
			@(negedge okClk);
			n++;
		end while (!cond_met(sel) && n < TIMEOUT);
		if (!cond_met(sel)) begin
			halted = 1'b1;
			$display("no %s within %0d cycles, giving up", what, TIMEOUT);
		end
	endtask

	task automatic next_gap(input bit gapped, output int gap);
		gap = 0;
		if (gapped) begin
			lcg_state = lcg_step(lcg_state);
			gap = int'(lcg_state[30:29]);    // 0 to 3 idle cycles
		end
	endtask

	// ------------------------------
	// pipe-in and pipe-out drivers
	// ------------------------------
	task automatic write_words(input int first, input int n, input bit gapped);
		int gap;
		int i;
		wait_until(SEL_PI, "pi_ready before a write");
		if (halted) return;
		for (i = 0; i < n; i++) begin
			next_gap(gapped, gap);
			repeat (gap) begin
				@(posedge okClk);
				pi_write <= 1'b0;
			end
			@(posedge okClk);
			pi_write <= 1'b1;
			pi_data  <= words[first + i];
		end
		@(posedge okClk);
		pi_write <= 1'b0;
	endtask

	task automatic read_block(input bit gapped);
		int gap;
		int i;
		wait_until(SEL_PO, "po_ready before a read");
		if (halted) return;
		for (i = 0; i < BLOCK_WORDS; i++) begin
			next_gap(gapped, gap);
			repeat (gap) begin
				@(posedge okClk);
				po_read <= 1'b0;
			end
			@(posedge okClk);
			po_read <= 1'b1;
		end
		@(posedge okClk);
		po_read <= 1'b0;
		@(posedge okClk);    // po_ready trails the count by a cycle
	endtask

	task automatic load_record(input int want_tag, output bit en);
		fp_pkg::op_desc_t d;
		int n;
		int i;
		en = 1'b0;
		words.delete();
		if (golden[rp] != want_tag) begin
			halted = 1'b1;
			$display("golden file out of step, found tag %h for test %0d", golden[rp], want_tag);
			return;
		end
		en = golden[rp + 1][0];
		n  = int'(golden[rp + 2]);
		rp += 3;
		for (i = 0; i < n; i++) begin
			words.push_back(golden[rp + i]);
			if (!en) checker_i.expect_word(golden[rp + i]);    // loopback keeps order
		end
		rp += n;
		n = int'(golden[rp]);
		rp++;
		for (i = 0; i < n; i++) begin
			d.op_type        = fp_pkg::op_type_t'(golden[rp][2:0]);
			d.op_num         = golden[rp + 1][15:0];
			d.data_addr      = golden[rp + 2][29:0];
			d.weight_addr    = golden[rp + 3][29:0];
			d.writeback_addr = golden[rp + 4][29:0];
			checker_i.expect_desc(d);
			rp += 5;
		end
	endtask

	// ------------------------------
	// tests
	// ------------------------------
	task automatic check_reset();
		wait_until(SEL_PI, "pi_ready after reset");
		if (halted) return;
		if (po_ready !== 1'b0 || op_valid !== 1'b0) begin
			tb_errors++;
			$display("Error %0t: po_ready %b op_valid %b after reset, expected low",
				$time, po_ready, op_valid);
		end
	endtask

	task automatic run_loopback(input bit gapped);
		bit seen_high;
		seen_high = 1'b0;
		write_words(0, BLOCK_WORDS, gapped);
		write_words(BLOCK_WORDS, BLOCK_WORDS, gapped);
		read_block(gapped);
		read_block(gapped);
		write_words(8, 3, gapped);    // a partial block only
		if (halted) return;
		repeat (8) begin
			@(negedge okClk);
			seen_high |= po_ready;
		end
		if (seen_high) begin
			tb_errors++;
			$display("Error %0t: po_ready high with 3 words in the output FIFO", $time);
		end
		write_words(11, 1, gapped);
		read_block(gapped);
	endtask

	task automatic run_command(input bit hold_off);
		int  blk;
		int  written;
		bit  throttled;
		written   = 0;
		throttled = 1'b0;
		@(posedge okClk);
		op_ready <= !hold_off;
		for (blk = 0; blk < words.size() / fp_pkg::CMD_WORDS; blk++) begin
			if (hold_off && !throttled) begin
				@(negedge okClk);
				if (!pi_ready) begin
					throttled = 1'b1;
					if (!op_valid || written - fp_pkg::CMD_WORDS <= THRESHOLD) begin
						tb_errors++;
						$display("Error %0t: throttle after %0d words, op_valid %b",
							$time, written, op_valid);
					end
					@(posedge okClk);
					op_ready <= 1'b1;    // let the waiting descriptor go
				end
			end
			write_words(blk * fp_pkg::CMD_WORDS, fp_pkg::CMD_WORDS, 1'b0);
			if (halted) return;
			written += fp_pkg::CMD_WORDS;
		end
		wait_until(SEL_DRAINED, "transfer of every descriptor");
		if (halted) return;
		if (hold_off && !throttled) begin
			tb_errors++;
			$display("pi_ready never dropped while a descriptor was held back");
		end
		wait_until(SEL_PI, "pi_ready after the backlog drained");
	endtask

	task automatic run_test(input int t);
		int errs_before;
		bit en;
		errs_before = tb_errors + checker_i.errors;
		load_record(t, en);
		if (!halted) begin
			@(posedge okClk);
			op_en <= en;    // input FIFO is empty between tests
			case (t)
				1:       check_reset();
				2:       run_loopback(1'b0);
				3:       run_loopback(1'b1);
				4:       run_command(1'b0);
				default: run_command(1'b1);
			endcase
		end
		if (!halted && checker_i.pending() != 0) begin
			tb_errors++;
			$display("%0d expected results never showed up", checker_i.pending());
		end
		if (halted || tb_errors + checker_i.errors != errs_before) begin
			tests_failed++;
			$display("test %0d %s: fail", t, test_names[t - 1]);
		end else begin
			$display("test %0d %s: pass", t, test_names[t - 1]);
		end
	endtask

	initial begin
		rst_n        = 1'b0;
		op_en        = 1'b0;
		pi_write     = 1'b0;
		pi_data      = '0;
		po_read      = 1'b0;
		op_ready     = 1'b0;
		lcg_state    = 32'h808d1f6e;
		rp           = 0;
		halted       = 1'b0;
		tb_errors    = 0;
		tests_failed = 0;
		$readmemh("test/golden_vectors.hex", golden);
		repeat (2) @(posedge okClk);
		rst_n <= 1'b1;
		for (tag = 1; tag <= 5 && !halted; tag++) begin
			run_test(tag);
		end
		$display("tests run %0d, failed %0d, checks %0d, errors %0d", tag - 1, tests_failed,
			checker_i.checks, tb_errors + checker_i.errors);
		if (!halted && tests_failed == 0 && tb_errors + checker_i.errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// File: test/host_bridge_checker.sv
`timescale 1ns/1ps

module host_bridge_checker (
	input logic             okClk,
	input logic             rst_n,
	input logic             po_read,
	input fp_pkg::word_t    po_data,
	input logic             op_valid,
	input logic             op_ready,
	input fp_pkg::op_desc_t op_desc
);

	fp_pkg::word_t    exp_words [$];    // loopback words in write order
	fp_pkg::op_desc_t exp_descs [$];    // descriptors in block order
	int               checks = 0;
	int               errors = 0;

	task automatic expect_word(input fp_pkg::word_t w);
		exp_words.push_back(w);
	endtask

	task automatic expect_desc(input fp_pkg::op_desc_t d);
		exp_descs.push_back(d);
	endtask

	function automatic int pending();
		return exp_words.size() + exp_descs.size();
	endfunction

	// ------------------------------
	// pipe-out reads
	// ------------------------------
	always @(posedge okClk) begin
		fp_pkg::word_t want;
		if (rst_n && po_read) begin
			if (exp_words.size() == 0) begin
				errors++;
				$display("pipe-out read at %0t with no word left to expect", $time);
			end else begin
				want = exp_words.pop_front();
				checks++;
				if (po_data !== want) begin
					errors++;
					$display("Error %0t: po_data %h, expected %h", $time, po_data, want);
				end
			end
		end
	end

	// ------------------------------
	// descriptor transfers
	// ------------------------------
	always @(posedge okClk) begin
		fp_pkg::op_desc_t want;
		if (rst_n && op_valid && op_ready) begin
			if (exp_descs.size() == 0) begin
				errors++;
				$display("descriptor transfer at %0t with none left to expect", $time);
			end else begin
				want = exp_descs.pop_front();
				checks++;
				if (op_desc !== want) begin
					errors++;
					$display("Error %0t: descriptor %0d/%h/%h/%h/%h, expected %0d/%h/%h/%h/%h",
						$time, op_desc.op_type, op_desc.op_num, op_desc.data_addr,
						op_desc.weight_addr, op_desc.writeback_addr, want.op_type,
						want.op_num, want.data_addr, want.weight_addr, want.writeback_addr);
				end
			end
		end
	end

endmodule

// File: logic/host_bridge_top.sv
`timescale 1ns/1ps

module host_bridge_top #(
	parameter int BLOCK_WORDS = 128,
	parameter int FIFO_DEPTH  = 1024,
	parameter int HEADROOM    = 20
) (
	input  logic             okClk,
	input  logic             rst_n,
	input  logic             op_en,
	input  logic             pi_write,
	input  fp_pkg::word_t    pi_data,
	output logic             pi_ready,
	input  logic             po_read,
	output fp_pkg::word_t    po_data,
	output logic             po_ready,
	output logic             op_valid,
	input  logic             op_ready,
	output fp_pkg::op_desc_t op_desc
);

	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	logic             in_wr_en;
	fp_pkg::word_t    in_wr_data;
	logic [CNT_W-1:0] in_count;
	logic             in_empty;
	logic             in_pop;
	fp_pkg::word_t    in_data;
	logic             out_wr_en;
	fp_pkg::word_t    out_wr_data;
	logic             out_full;
	logic [CNT_W-1:0] out_count;
	logic             out_stall;
	logic             cmd_valid;
	logic             cmd_ready;
	fp_pkg::word_t    cmd_word;

	// ------------------------------
	// pipe-in side
	// ------------------------------
	pipe_in_gate #(
		.BLOCK_WORDS (BLOCK_WORDS),
		.FIFO_DEPTH  (FIFO_DEPTH),
		.HEADROOM    (HEADROOM)
	) pipe_in_gate_i (
		.okClk      (okClk),
		.rst_n      (rst_n),
		.pi_write   (pi_write),
		.pi_data    (pi_data),
		.fifo_count (in_count),
		.pi_ready   (pi_ready),
		.wr_en      (in_wr_en),
		.wr_data    (in_wr_data)
	);

	word_fifo #(.DEPTH(FIFO_DEPTH)) in_fifo_i (
		.okClk   (okClk),
		.rst_n   (rst_n),
		.wr_en   (in_wr_en),
		.wr_data (in_wr_data),
		.rd_en   (in_pop),
		.rd_data (in_data),
		.empty   (in_empty),
		.full    (),              // throttle keeps the host off a full fifo
		.count   (in_count)
	);

	// ------------------------------
	// routing and command parsing
	// ------------------------------
	// one loopback write may still be in flight behind the full flag
	assign out_stall = out_full || (out_wr_en && out_count == CNT_W'(FIFO_DEPTH - 1));

	word_router word_router_i (
		.okClk     (okClk),
		.rst_n     (rst_n),
		.op_en     (op_en),
		.in_empty  (in_empty),
		.in_data   (in_data),
		.in_pop    (in_pop),
		.out_full  (out_stall),
		.out_wr_en (out_wr_en),
		.out_data  (out_wr_data),
		.cmd_ready (cmd_ready),
		.cmd_valid (cmd_valid),
		.cmd_word  (cmd_word)
	);

	cmd_decoder cmd_decoder_i (
		.okClk     (okClk),
		.rst_n     (rst_n),
		.cmd_valid (cmd_valid),
		.cmd_word  (cmd_word),
		.cmd_ready (cmd_ready),
		.op_valid  (op_valid),
		.op_ready  (op_ready),
		.op_desc   (op_desc)
	);

	// ------------------------------
	// pipe-out side
	// ------------------------------
	word_fifo #(.DEPTH(FIFO_DEPTH)) out_fifo_i (
		.okClk   (okClk),
		.rst_n   (rst_n),
		.wr_en   (out_wr_en),
		.wr_data (out_wr_data),
		.rd_en   (po_read),
		.rd_data (po_data),       // head of fifo always visible
		.empty   (),
		.full    (out_full),
		.count   (out_count)
	);

	always_ff @(posedge okClk) begin
		if (!rst_n) begin
			po_ready <= 1'b0;
		end else begin
			po_ready <= (out_count >= CNT_W'(BLOCK_WORDS));    // a whole block is waiting
		end
	end

endmodule

// File: logic/cmd_decoder.sv
`timescale 1ns/1ps

module cmd_decoder (
	input  logic             okClk,
	input  logic             rst_n,
	input  logic             cmd_valid,
	input  fp_pkg::word_t    cmd_word,
	output logic             cmd_ready,
	output logic             op_valid,
	input  logic             op_ready,
	output fp_pkg::op_desc_t op_desc
);

	localparam int IDX_W = $clog2(fp_pkg::CMD_WORDS);

	fp_pkg::cmd_word_u word_view;   // header or address reading of a word
	fp_pkg::op_desc_t  desc_q;
	logic [IDX_W-1:0]  word_idx;    // position inside the command block
	logic              take;
	logic              last_word;

	assign word_view = cmd_word;
	assign cmd_ready = !op_valid;   // stall the router while a descriptor waits
	assign take      = cmd_valid && cmd_ready;
	assign last_word = (word_idx == IDX_W'(fp_pkg::CMD_WORDS - 1));
	assign op_desc   = desc_q;

	// ------------------------------
	// block word counter and valid
	// ------------------------------
	always_ff @(posedge okClk) begin
		if (!rst_n) begin
			word_idx <= '0;
			op_valid <= 1'b0;
		end else begin
			if (take) begin
				word_idx <= last_word ? '0 : word_idx + 1'b1;
			end
			if (take && last_word) begin
				op_valid <= 1'b1;       // descriptor complete
			end else if (op_valid && op_ready) begin
				op_valid <= 1'b0;       // taken downstream
			end
		end
	end

	// ------------------------------
	// descriptor fields, in block order
	// ------------------------------
	always_ff @(posedge okClk) begin
		if (take) begin
			case (word_idx)
				IDX_W'(0): begin
					desc_q.op_type <= word_view.header.op_type;
					desc_q.op_num  <= word_view.header.op_num;
				end
				IDX_W'(1): begin
					desc_q.data_addr <= word_view.addr.addr;
				end
				IDX_W'(2): begin
					desc_q.weight_addr <= word_view.addr.addr;
				end
				default: begin
					desc_q.writeback_addr <= word_view.addr.addr;
				end
			endcase
		end
	end

endmodule

// File: logic/word_router.sv
`timescale 1ns/1ps

module word_router (
	input  logic          okClk,
	input  logic          rst_n,
	input  logic          op_en,
	input  logic          in_empty,
	input  fp_pkg::word_t in_data,
	output logic          in_pop,
	input  logic          out_full,
	output logic          out_wr_en,
	output fp_pkg::word_t out_data,
	input  logic          cmd_ready,
	output logic          cmd_valid,
	output fp_pkg::word_t cmd_word
);

	logic loop_pop;
	logic cmd_pop;

	// ------------------------------
	// destination select
	// ------------------------------
	assign loop_pop = !op_en && !in_empty && !out_full;    // loopback to pipe-out
	assign cmd_pop  = op_en && !in_empty && cmd_ready;     // command parser
	assign in_pop   = loop_pop || cmd_pop;

	// command path is a direct valid/ready view of the fifo head
	assign cmd_valid = op_en && !in_empty;
	assign cmd_word  = in_data;

	// ------------------------------
	// registered loopback write
	// ------------------------------
	always_ff @(posedge okClk) begin
		if (!rst_n) begin
			out_wr_en <= 1'b0;
		end else begin
			out_wr_en <= loop_pop;
		end
	end

	always_ff @(posedge okClk) begin
		if (loop_pop) begin
			out_data <= in_data;    // lands one cycle after the pop
		end
	end

endmodule

// File: logic/pipe_in_gate.sv
`timescale 1ns/1ps

module pipe_in_gate #(
	parameter int BLOCK_WORDS = 128,
	parameter int FIFO_DEPTH  = 1024,
	parameter int HEADROOM    = 20
) (
	input  logic                            okClk,
	input  logic                            rst_n,
	input  logic                            pi_write,
	input  fp_pkg::word_t                   pi_data,
	input  logic [$clog2(FIFO_DEPTH+1)-1:0] fifo_count,
	output logic                            pi_ready,
	output logic                            wr_en,
	output fp_pkg::word_t                   wr_data
);

	localparam int CNT_W     = $clog2(FIFO_DEPTH + 1);
	localparam int BLK_W     = $clog2(BLOCK_WORDS + 1);
	localparam int THRESHOLD = FIFO_DEPTH - HEADROOM - BLOCK_WORDS;

	logic [BLK_W-1:0] blk_cnt;    // words seen in the current block
	logic [CNT_W:0]   level;      // fifo level including a word landing now
	logic             last_word;
	logic             idle;
	logic             room_ok;

	assign level     = fifo_count + (pi_write ? 1'b1 : 1'b0);
	assign room_ok   = (int'(level) <= THRESHOLD);
	assign last_word = pi_write && (blk_cnt == BLK_W'(BLOCK_WORDS - 1));
	assign idle      = !pi_write && (blk_cnt == '0);

	always_ff @(posedge okClk) begin
		if (!rst_n) begin
			blk_cnt  <= '0;
			pi_ready <= 1'b0;
		end else begin
			if (pi_write) begin
				blk_cnt <= last_word ? '0 : blk_cnt + 1'b1;
			end
			// held through a block, re-checked at its end and while idle
			if (last_word || idle) begin
				pi_ready <= room_ok;
			end
		end
	end

	assign wr_en   = pi_write;    // every host write is taken
	assign wr_data = pi_data;

endmodule

// File: logic/word_fifo.sv
`timescale 1ns/1ps

module word_fifo #(
	parameter int DEPTH = 32
) (
	input  logic                       okClk,
	input  logic                       rst_n,
	input  logic                       wr_en,
	input  fp_pkg::word_t              wr_data,
	input  logic                       rd_en,
	output fp_pkg::word_t              rd_data,
	output logic                       empty,
	output logic                       full,
	output logic [$clog2(DEPTH+1)-1:0] count
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	fp_pkg::word_t    mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic             push;
	logic             pop;

	assign push    = wr_en && !full;     // writes into a full fifo are dropped
	assign pop     = rd_en && !empty;
	assign empty   = (count == '0);
	assign full    = (count == CNT_W'(DEPTH));
	assign rd_data = mem[rd_ptr];        // head word shows without latency

	// ------------------------------
	// storage
	// ------------------------------
	always_ff @(posedge okClk) begin
		if (push) begin
			mem[wr_ptr] <= wr_data;
		end
	end

	// ------------------------------
	// pointers and occupancy
	// ------------------------------
	always_ff @(posedge okClk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;    // idle or push and pop together
			endcase
		end
	end

endmodule

// File: logic/fp_pkg.sv
package fp_pkg;

	// ------------------------------
	// basic pipe and memory types
	// ------------------------------
	typedef logic [31:0] word_t;     // one pipe word
	typedef logic [29:0] addr_t;     // DDR word address
	typedef logic [15:0] op_num_t;   // operation count

	typedef enum logic [2:0] {
		OP_CONV3X3 = 3'd0,
		OP_CONV1X1 = 3'd1,
		OP_MAXPOOL = 3'd2,
		OP_AVEPOOL = 3'd3
	} op_type_t;

	localparam int CMD_WORDS = 4;    // words per command block

	// ------------------------------
	// command block word views
	// ------------------------------
	typedef struct packed {
		op_type_t    op_type;
		logic [12:0] reserved;
		op_num_t     op_num;
	} cmd_header_t;

	typedef struct packed {
		logic [1:0] zero;            // upper bits unused by the address
		addr_t      addr;
	} cmd_addr_t;

	// word 0 of a block is a header, words 1..3 are addresses
	typedef union packed {
		cmd_header_t header;
		cmd_addr_t   addr;
	} cmd_word_u;

	typedef struct packed {
		op_type_t op_type;
		op_num_t  op_num;
		addr_t    data_addr;
		addr_t    weight_addr;
		addr_t    writeback_addr;
	} op_desc_t;                     // 109 bits

endpackage
